// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_pkg.sv
      - logic/rv_fetch.sv
      - logic/rv_decode.sv
      - logic/rv_execute.sv
      - logic/rv_regfile.sv
      - logic/rv_lsu.sv
      - logic/rv_flow.sv
      - logic/rv_core.sv
  - target: simulation
    files:
      - bench/core_assertions.sv
      - bench/tb_core.sv

// ==== bench/core_assertions.sv ====
// ==================================================
// port protocol checks bound into rv_core
// all checks are off while rst_n is low
// ==================================================
module core_assertions (
   input logic             clk,
   input logic             rst_n,
   input rv_pkg::addr_t    code_addr,
   input rv_pkg::bytesel_t data_bytesel,
   input logic             data_req
);

   timeunit 1ns;
   timeprecision 100ps;

   // count of failed assertions
   int failures = 0;

   // write lanes only with a request
   lanes_need_req: assert property (@(posedge clk) disable iff (!rst_n)
      (data_bytesel != 4'b0000) |-> data_req)
      else begin
         $error("data_bytesel is set while data_req is low");
         failures++;
      end

   // the cycle after a read is the load wait
   read_req_single: assert property (@(posedge clk) disable iff (!rst_n)
      (data_req && (data_bytesel == 4'b0000)) |=> !data_req)
      else begin
         $error("data_req stayed high after a read request");
         failures++;
      end

   code_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      code_addr[1:0] == 2'b00)
      else begin
         $error("code_addr is not word aligned");
         failures++;
      end

endmodule

// ==== bench/tb_core.sv ====
// ==================================================
// directed tests for the two-stage core
// code and data memories hold 256 words each
// every program ends with a store to the done address
// ==================================================
module tb_core;

   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] DONE_ADDR = 32'h0000_0100;
   localparam int          TIMEOUT_CYCLES = 2000;
   localparam logic [6:0]  OP_REG    = 7'b0110011;
   localparam logic [6:0]  OP_IMM    = 7'b0010011;
   localparam logic [6:0]  OP_LUI    = 7'b0110111;
   localparam logic [6:0]  OP_BRANCH = 7'b1100011;
   localparam logic [6:0]  OP_JAL    = 7'b1101111;
   localparam logic [6:0]  OP_LOAD   = 7'b0000011;
   localparam logic [6:0]  OP_STORE  = 7'b0100011;

   logic             clk;
   logic             rst_n;
   rv_pkg::addr_t    code_addr;
   rv_pkg::instr_t   code_rdata;
   rv_pkg::addr_t    data_addr;
   rv_pkg::word_t    data_wdata;
   rv_pkg::bytesel_t data_bytesel;
   logic             data_req;
   rv_pkg::word_t    data_rdata;

   logic [31:0] cmem [0:255];
   logic [31:0] dmem [0:255];
   logic [31:0] code_next;
   logic [31:0] data_next;
   logic [31:0] lfsr;
   logic        done;
   int          prog_pc;
   int          errors;
   int          test_errors;
   int          tests_run;

   rv_core DUT (
      .clk(clk), .rst_n(rst_n), .code_addr(code_addr), .code_rdata(code_rdata),
      .data_addr(data_addr), .data_wdata(data_wdata), .data_bytesel(data_bytesel),
      .data_req(data_req), .data_rdata(data_rdata)
   );

   bind rv_core core_assertions u_core_assertions (
      .clk(clk), .rst_n(rst_n), .code_addr(code_addr),
      .data_bytesel(data_bytesel), .data_req(data_req)
   );

   always #5 clk = ~clk;

   // ==================================================
   // memory models
   // ==================================================
   // outputs are settled at the falling edge
   always @(negedge clk) begin
      code_next = cmem[code_addr[9:2]];
      if (data_req && (data_bytesel == 4'b0000))
         data_next = dmem[data_addr[9:2]];
      if (data_req && (data_bytesel != 4'b0000)) begin
         for (int i = 0; i < 4; i++)
            if (data_bytesel[i])
               dmem[data_addr[9:2]][8*i +: 8] = data_wdata[8*i +: 8];
         if (data_addr == DONE_ADDR)
            done = 1'b1;
      end
   end

   // answers arrive one cycle after the address
   always @(posedge clk) begin
      #1;
      code_rdata = code_next;
      data_rdata = data_next;
   end

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'hB4BC_D35C;
      else
         return s >> 1;
   endfunction

   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [31:0] fill_word(int idx);
      return 32'hF00D_0000 | (idx * 4);
   endfunction

   // ==================================================
   // instruction encoders
   // ==================================================
   function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3,
                                          logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic logic [31:0] i_type(logic [6:0] opc, logic [2:0] f3,
                                          logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] s_type(logic [2:0] f3, logic [4:0] rs2,
                                          logic [4:0] rs1, logic [11:0] imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
   endfunction

   function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1,
                                          logic [4:0] rs2, logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
   endfunction

   function automatic logic [31:0] u_type(logic [4:0] rd, logic [19:0] upper);
      return {upper, rd, OP_LUI};
   endfunction

   function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
   endfunction

   task automatic emit(logic [31:0] w);
      cmem[prog_pc / 4] = w;
      prog_pc += 4;
   endtask

   // lui then addi with the upper part rounded for the signed low half
   task automatic load_const(logic [4:0] rd, logic [31:0] value);
      logic [31:0] upper;
      upper = (value + 32'h800) >> 12;
      emit(u_type(rd, upper[19:0]));
      emit(i_type(OP_IMM, 3'b000, rd, rd, value[11:0]));
   endtask

   // ==================================================
   // test sequencing and checking
   // ==================================================
   task automatic start_program();
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      done = 1'b0;
      prog_pc = 0;
      test_errors = 0;
      for (int i = 0; i < 256; i++) begin
         // addi x0, x0, byte address
         cmem[i] = i_type(OP_IMM, 3'b000, 5'd0, 5'd0, 12'(i * 4));
         dmem[i] = fill_word(i);
      end
   endtask

   task automatic run_program(string name);
      int cycles;
      emit(s_type(3'b010, 5'd0, 5'd0, DONE_ADDR[11:0]));
      // park in a one-word loop
      emit(j_type(5'd0, 21'd0));
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      cycles = 0;
      while (!done && (cycles < TIMEOUT_CYCLES)) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!done) begin
         $display("test %s timed out: the core never stored to the done address", name);
         test_errors++;
      end
   endtask

   task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
      if (actual !== expected) begin
         $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic report_test(string name);
      tests_run++;
      errors += test_errors;
      if (test_errors == 0)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, test_errors);
   endtask

   // ==================================================
   // tests
   // ==================================================
   task automatic alu_test();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] expected [8];
      logic [2:0]  f3 [7];
      a = rand_bits(32);
      b = rand_bits(32);
      // add sub and or xor sll srl
      f3 = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b001, 3'b101};
      expected = '{a + b, a - b, a & b, a | b, a ^ b, a << b[4:0], a >> b[4:0], a - 32'd1000};
      start_program();
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (int k = 0; k < 7; k++) begin
         emit(r_type((k == 1) ? 7'b0100000 : 7'b0000000, f3[k], 5'd3, 5'd1, 5'd2));
         emit(s_type(3'b010, 5'd3, 5'd0, 12'(4 * k)));
      end
      emit(i_type(OP_IMM, 3'b000, 5'd4, 5'd1, 12'(-1000)));
      emit(s_type(3'b010, 5'd4, 5'd0, 12'd28));
      run_program("alu");
      for (int k = 0; k < 8; k++)
         check($sformatf("alu op %0d", k), expected[k], dmem[k]);
      report_test("alu");
   endtask

   task automatic branch_test();
      int n;
      int m;
      int loop_pc;
      n = 1 + rand_bits(3);
      m = 1 + rand_bits(3);
      start_program();
      // BNE countdown with x2 counting the passes
      emit(i_type(OP_IMM, 3'b000, 5'd1, 5'd0, 12'(n)));
      loop_pc = prog_pc;
      emit(i_type(OP_IMM, 3'b000, 5'd1, 5'd1, 12'(-1)));
      emit(i_type(OP_IMM, 3'b000, 5'd2, 5'd2, 12'd1));
      emit(b_type(3'b001, 5'd1, 5'd0, 13'(loop_pc - prog_pc)));
      emit(s_type(3'b010, 5'd2, 5'd0, 12'd0));
      // taken BEQ skips a store and untaken BNE keeps one
      emit(b_type(3'b000, 5'd1, 5'd0, 13'd8));
      emit(s_type(3'b010, 5'd2, 5'd0, 12'd4));
      emit(b_type(3'b001, 5'd0, 5'd0, 13'd8));
      emit(s_type(3'b010, 5'd2, 5'd0, 12'd8));
      // BEQ as the loop exit
      emit(i_type(OP_IMM, 3'b000, 5'd3, 5'd0, 12'(m)));
      loop_pc = prog_pc;
      emit(b_type(3'b000, 5'd3, 5'd0, 13'd16));
      emit(i_type(OP_IMM, 3'b000, 5'd3, 5'd3, 12'(-1)));
      emit(i_type(OP_IMM, 3'b000, 5'd4, 5'd4, 12'd1));
      emit(j_type(5'd0, 21'(loop_pc - prog_pc)));
      emit(s_type(3'b010, 5'd4, 5'd0, 12'd12));
      emit(s_type(3'b010, 5'd3, 5'd0, 12'd16));
      run_program("branch");
      check("branch bne passes", n, dmem[0]);
      check("branch taken beq", fill_word(1), dmem[1]);
      check("branch untaken bne", n, dmem[2]);
      check("branch beq passes", m, dmem[3]);
      check("branch final counter", 32'd0, dmem[4]);
      report_test("branch");
   endtask

   task automatic jal_test();
      int jal_pc;
      start_program();
      emit(i_type(OP_IMM, 3'b000, 5'd7, 5'd0, 12'h055));
      emit(i_type(OP_IMM, 3'b000, 5'd0, 5'd0, 12'd0));
      jal_pc = prog_pc;
      emit(j_type(5'd5, 21'd12));
      emit(s_type(3'b010, 5'd7, 5'd0, 12'd4));
      emit(s_type(3'b010, 5'd7, 5'd0, 12'd8));
      emit(s_type(3'b010, 5'd5, 5'd0, 12'd0));
      run_program("jal");
      check("jal link", jal_pc + 4, dmem[0]);
      check("jal skipped store 1", fill_word(1), dmem[1]);
      check("jal skipped store 2", fill_word(2), dmem[2]);
      report_test("jal");
   endtask

   task automatic load_test();
      logic [31:0] w;
      logic [7:0]  b;
      // lanes 1 and 3 negative and lanes 0 and 2 positive
      w = (rand_bits(32) | 32'h8000_8000) & 32'hFF7F_FF7F;
      start_program();
      dmem[32] = w;
      emit(i_type(OP_LOAD, 3'b010, 5'd1, 5'd0, 12'h080));
      emit(s_type(3'b010, 5'd1, 5'd0, 12'd0));
      for (int k = 0; k < 4; k++) begin
         emit(i_type(OP_LOAD, 3'b000, 5'd2, 5'd0, 12'(128 + k)));
         emit(s_type(3'b010, 5'd2, 5'd0, 12'(4 + 8 * k)));
         emit(i_type(OP_LOAD, 3'b100, 5'd3, 5'd0, 12'(128 + k)));
         emit(s_type(3'b010, 5'd3, 5'd0, 12'(8 + 8 * k)));
      end
      run_program("load");
      check("load lw", w, dmem[0]);
      for (int k = 0; k < 4; k++) begin
         b = w[8*k +: 8];
         check($sformatf("load lb offset %0d", k), {{24{b[7]}}, b}, dmem[1 + 2 * k]);
         check($sformatf("load lbu offset %0d", k), {24'b0, b}, dmem[2 + 2 * k]);
      end
      report_test("load");
   endtask

   task automatic store_byte_test();
      logic [31:0] v [4];
      logic [31:0] word_val;
      logic [31:0] expected;
      for (int k = 0; k < 4; k++)
         v[k] = rand_bits(32);
      word_val = rand_bits(32);
      start_program();
      // byte k of the word at 0x40 + 4k
      for (int k = 0; k < 4; k++) begin
         load_const(5'd1, v[k]);
         emit(s_type(3'b000, 5'd1, 5'd0, 12'(64 + 5 * k)));
      end
      emit(s_type(3'b000, 5'd1, 5'd0, 12'h051));
      load_const(5'd2, word_val);
      emit(s_type(3'b010, 5'd2, 5'd0, 12'h050));
      run_program("store_byte");
      for (int k = 0; k < 4; k++) begin
         expected = fill_word(16 + k);
         expected[8*k +: 8] = v[k][7:0];
         check($sformatf("sb offset %0d", k), expected, dmem[16 + k]);
      end
      check("sw after sb", word_val, dmem[20]);
      report_test("store_byte");
   endtask

   task automatic zero_reg_test();
      start_program();
      dmem[32] = rand_bits(32) | 32'h1;
      emit(i_type(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5));
      emit(i_type(OP_IMM, 3'b000, 5'd0, 5'd0, 12'h123));
      emit(u_type(5'd0, 20'hABCDE));
      emit(r_type(7'b0000000, 3'b000, 5'd0, 5'd1, 5'd1));
      emit(s_type(3'b010, 5'd0, 5'd0, 12'd0));
      emit(i_type(OP_LOAD, 3'b010, 5'd0, 5'd0, 12'h080));
      emit(s_type(3'b010, 5'd0, 5'd0, 12'd4));
      emit(j_type(5'd0, 21'd4));
      emit(s_type(3'b010, 5'd0, 5'd0, 12'd8));
      run_program("zero_reg");
      for (int k = 0; k < 3; k++)
         check($sformatf("x0 store %0d", k), 32'd0, dmem[k]);
      report_test("zero_reg");
   endtask

   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      // addi x0, x0, 0
      code_rdata = 32'h0000_0013;
      code_next = 32'h0000_0013;
      data_rdata = '0;
      data_next = '0;
      done = 1'b0;
      lfsr = 32'd96598;
      errors = 0;
      tests_run = 0;
      alu_test();
      branch_test();
      jal_test();
      load_test();
      store_byte_test();
      zero_reg_test();
      errors += DUT.u_core_assertions.failures;
      $display("%0d tests run, %0d errors", tests_run, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== logic/rv_core.sv ====
// ==================================================
// two-stage RV32I subset core
// code and data memories answer one cycle late
// data_req pulses once per access, bytesel 0 = read
// ==================================================
module rv_core (
   input  logic             clk,
   input  logic             rst_n,
   output rv_pkg::addr_t    code_addr,
   input  rv_pkg::instr_t   code_rdata,
   output rv_pkg::addr_t    data_addr,
   output rv_pkg::word_t    data_wdata,
   output rv_pkg::bytesel_t data_bytesel,
   output logic             data_req,
   input  rv_pkg::word_t    data_rdata
);

   rv_pkg::instr_t    instr;
   rv_pkg::addr_t     pc_exe, target;
   rv_pkg::reg_idx_t  rs1, rs2, rd;
   rv_pkg::word_t     imm, alu_res, rs1_data, rs2_data, rd_data, load_data;
   rv_pkg::alu_op_e   alu_op;
   rv_pkg::opa_sel_e  opa_sel;
   rv_pkg::opb_sel_e  opb_sel;
   rv_pkg::wb_sel_e   wb_sel;
   rv_pkg::pc_sel_e   pc_sel;
   rv_pkg::mem_size_e mem_size;
   logic reg_write, mem_read, mem_write, branch_ne;
   logic take_branch, jump, stall, bubble, access_ok, in_waitld;
   logic rf_we;

   rv_fetch u_fetch (
      .clk(clk), .rst_n(rst_n), .stall(stall), .bubble(bubble),
      .take_branch(take_branch), .target(target), .code_rdata(code_rdata),
      .code_addr(code_addr), .instr(instr), .pc_exe(pc_exe)
   );

   rv_decode u_decode (
      .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
      .alu_op(alu_op), .opa_sel(opa_sel), .opb_sel(opb_sel), .wb_sel(wb_sel),
      .pc_sel(pc_sel), .mem_size(mem_size), .reg_write(reg_write),
      .mem_read(mem_read), .mem_write(mem_write), .branch_ne(branch_ne)
   );

   rv_regfile u_regfile (
      .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
      .rd_data(rd_data), .write_en(rf_we), .rs1_data(rs1_data), .rs2_data(rs2_data)
   );

   rv_execute u_execute (
      .pc_exe(pc_exe), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
      .alu_op(alu_op), .opa_sel(opa_sel), .opb_sel(opb_sel), .pc_sel(pc_sel),
      .branch_ne(branch_ne), .alu_res(alu_res), .take_branch(take_branch),
      .jump(jump), .target(target)
   );

   // stores only in the first execute cycle
   rv_lsu u_lsu (
      .alu_res(alu_res), .rs2_data(rs2_data), .data_rdata(data_rdata),
      .mem_size(mem_size), .mem_write(mem_write && access_ok),
      .wdata(data_wdata), .bytesel(data_bytesel), .load_data(load_data)
   );

   rv_flow u_flow (
      .clk(clk), .rst_n(rst_n), .take_branch(take_branch), .mem_read(mem_read),
      .stall(stall), .bubble(bubble), .access_ok(access_ok), .in_waitld(in_waitld)
   );

   // ==================================================
   // writeback and data port glue
   // ==================================================
   always_comb begin
      case (wb_sel)
         rv_pkg::WB_MEM:  rd_data = load_data;
         rv_pkg::WB_LINK: rd_data = pc_exe + 32'd4;
         default:         rd_data = alu_res;
      endcase
   end

   // a load writes rd only once its data is back
   assign rf_we = !stall && (reg_write || jump) && (in_waitld || !mem_read);

   assign data_addr = alu_res;
   assign data_req  = (mem_read || mem_write) && access_ok;

endmodule

// ==== logic/rv_decode.sv ====
// ==================================================
// RV32I subset decoder
// unknown encodings fall through to a no-op
// JAL leaves reg_write low, its link write follows jump
// ==================================================
module rv_decode (
   input  rv_pkg::instr_t    instr,
   output rv_pkg::reg_idx_t  rs1,
   output rv_pkg::reg_idx_t  rs2,
   output rv_pkg::reg_idx_t  rd,
   output rv_pkg::word_t     imm,
   output rv_pkg::alu_op_e   alu_op,
   output rv_pkg::opa_sel_e  opa_sel,
   output rv_pkg::opb_sel_e  opb_sel,
   output rv_pkg::wb_sel_e   wb_sel,
   output rv_pkg::pc_sel_e   pc_sel,
   output rv_pkg::mem_size_e mem_size,
   output logic              reg_write,
   output logic              mem_read,
   output logic              mem_write,
   output logic              branch_ne
);

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   rv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign rd     = instr[11:7];

   // ==================================================
   // immediate reconstruction
   // ==================================================
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      imm       = imm_i;
      alu_op    = rv_pkg::ALU_ADD;
      opa_sel   = rv_pkg::OPA_RS1;
      opb_sel   = rv_pkg::OPB_RS2;
      wb_sel    = rv_pkg::WB_ALU;
      pc_sel    = rv_pkg::PC_PLUS4;
      mem_size  = rv_pkg::SIZE_WORD;
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      branch_ne = 1'b0;
      case (opcode)
         OPC_OP: begin
            reg_write = 1'b1;
            case ({funct7, funct3})
               10'b0000000_000: alu_op = rv_pkg::ALU_ADD;
               10'b0100000_000: alu_op = rv_pkg::ALU_SUB;
               10'b0000000_001: alu_op = rv_pkg::ALU_SLL;
               10'b0000000_100: alu_op = rv_pkg::ALU_XOR;
               10'b0000000_101: alu_op = rv_pkg::ALU_SRL;
               10'b0000000_110: alu_op = rv_pkg::ALU_OR;
               10'b0000000_111: alu_op = rv_pkg::ALU_AND;
               default: reg_write = 1'b0;
            endcase
         end
         OPC_OP_IMM: begin
            // ADDI only
            opb_sel   = rv_pkg::OPB_IMM_I;
            reg_write = (funct3 == 3'b000);
         end
         OPC_LUI: begin
            imm       = imm_u;
            alu_op    = rv_pkg::ALU_PASSB;
            opb_sel   = rv_pkg::OPB_IMM_U;
            reg_write = 1'b1;
         end
         OPC_BRANCH: begin
            imm       = imm_b;
            pc_sel    = (funct3[2:1] == 2'b00) ? rv_pkg::PC_BRANCH : rv_pkg::PC_PLUS4;
            branch_ne = funct3[0];
         end
         OPC_JAL: begin
            imm     = imm_j;
            opa_sel = rv_pkg::OPA_PC;
            opb_sel = rv_pkg::OPB_IMM_U;
            wb_sel  = rv_pkg::WB_LINK;
            pc_sel  = rv_pkg::PC_JUMP;
         end
         OPC_LOAD: begin
            opb_sel = rv_pkg::OPB_IMM_I;
            wb_sel  = rv_pkg::WB_MEM;
            case (funct3)
               3'b010: mem_size = rv_pkg::SIZE_WORD;
               3'b000: mem_size = rv_pkg::SIZE_BYTE;
               default: mem_size = rv_pkg::SIZE_BYTE_U;
            endcase
            mem_read  = (funct3 == 3'b010) || (funct3 == 3'b000) || (funct3 == 3'b100);
            reg_write = mem_read;
         end
         OPC_STORE: begin
            imm       = imm_s;
            opb_sel   = rv_pkg::OPB_IMM_S;
            mem_size  = (funct3 == 3'b000) ? rv_pkg::SIZE_BYTE : rv_pkg::SIZE_WORD;
            mem_write = (funct3 == 3'b000) || (funct3 == 3'b010);
         end
         default: begin
         end
      endcase
   end

endmodule

// ==== logic/rv_execute.sv ====
// ==================================================
// execute stage ALU and next-PC choice
// shifts use the low five bits of operand b
// target is pc_exe + imm for both branches and JAL
// ==================================================
module rv_execute (
   input  rv_pkg::addr_t    pc_exe,
   input  rv_pkg::word_t    rs1_data,
   input  rv_pkg::word_t    rs2_data,
   input  rv_pkg::word_t    imm,
   input  rv_pkg::alu_op_e  alu_op,
   input  rv_pkg::opa_sel_e opa_sel,
   input  rv_pkg::opb_sel_e opb_sel,
   input  rv_pkg::pc_sel_e  pc_sel,
   input  logic             branch_ne,
   output rv_pkg::word_t    alu_res,
   output logic             take_branch,
   output logic             jump,
   output rv_pkg::addr_t    target
);

   rv_pkg::word_t opa;
   rv_pkg::word_t opb;
   logic          cond;

   assign opa = (opa_sel == rv_pkg::OPA_PC) ? pc_exe : rs1_data;

   // every immediate arrives on the same port
   assign opb = (opb_sel == rv_pkg::OPB_RS2) ? rs2_data : imm;

   always_comb begin
      case (alu_op)
         rv_pkg::ALU_ADD: alu_res = opa + opb;
         rv_pkg::ALU_SUB: alu_res = opa - opb;
         rv_pkg::ALU_AND: alu_res = opa & opb;
         rv_pkg::ALU_OR:  alu_res = opa | opb;
         rv_pkg::ALU_XOR: alu_res = opa ^ opb;
         rv_pkg::ALU_SLL: alu_res = opa << opb[4:0];
         rv_pkg::ALU_SRL: alu_res = opa >> opb[4:0];
         default:         alu_res = opb;
      endcase
   end

   // BEQ on equality and BNE on its inverse
   assign cond        = (rs1_data == rs2_data) ^ branch_ne;
   assign jump        = (pc_sel == rv_pkg::PC_JUMP);
   assign take_branch = jump || ((pc_sel == rv_pkg::PC_BRANCH) && cond);
   assign target      = pc_exe + imm;

endmodule

// ==== logic/rv_fetch.sv ====
// ==================================================
// fetch stage, code memory answers one cycle late
// code_addr is combinational from the execute stage
// a squashed word leaves this stage as the NOP
// ==================================================
`include "rv_params.svh"

module rv_fetch (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           stall,
   input  logic           bubble,
   input  logic           take_branch,
   input  rv_pkg::addr_t  target,
   input  rv_pkg::instr_t code_rdata,
   output rv_pkg::addr_t  code_addr,
   output rv_pkg::instr_t instr,
   output rv_pkg::addr_t  pc_exe
);

   // address of the word now on code_rdata
   rv_pkg::addr_t  pc_fetch;
   rv_pkg::instr_t instr_q;

   // redirect wins over a hold
   always_comb begin
      if (take_branch)
         code_addr = target;
      else if (stall)
         code_addr = pc_fetch;
      else
         code_addr = pc_fetch + 32'd4;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_fetch <= `RV_RESET_PC;
         pc_exe   <= `RV_RESET_PC;
         instr_q  <= `RV_NOP_WORD;
      end else begin
         pc_fetch <= code_addr;
         if (!stall) begin
            pc_exe  <= pc_fetch;
            instr_q <= code_rdata;
         end
      end
   end

   assign instr = bubble ? rv_pkg::instr_t'(`RV_NOP_WORD) : instr_q;

endmodule

// ==== logic/rv_flow.sv ====
// ==================================================
// pipeline flow FSM
// memories have no wait states, so every state but
// CONT lasts exactly one cycle
// ==================================================
module rv_flow (
   input  logic clk,
   input  logic rst_n,
   input  logic take_branch,
   input  logic mem_read,
   output logic stall,
   output logic bubble,
   output logic access_ok,
   output logic in_waitld
);

   rv_pkg::flow_state_e state, state_next;

   always_comb begin
      state_next = rv_pkg::ST_CONT;
      if ((state == rv_pkg::ST_CONT) && take_branch)
         state_next = rv_pkg::ST_BRANCH;
      else if ((state == rv_pkg::ST_CONT) && mem_read)
         state_next = rv_pkg::ST_WAITLD;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= rv_pkg::ST_RESET;
      else
         state <= state_next;
   end

   // load holds its slot until read data is back
   assign stall     = (state == rv_pkg::ST_RESET) ||
                      ((state == rv_pkg::ST_CONT) && mem_read);
   // word behind a redirect is dropped
   assign bubble    = (state == rv_pkg::ST_RESET) || (state == rv_pkg::ST_BRANCH);
   assign access_ok = (state == rv_pkg::ST_CONT);
   assign in_waitld = (state == rv_pkg::ST_WAITLD);

endmodule

// ==== logic/rv_lsu.sv ====
// ==================================================
// byte lane handling for loads and stores
// no halfword access, no misalignment trap
// a word access ignores the low address bits
// ==================================================
module rv_lsu (
   input  rv_pkg::word_t     alu_res,
   input  rv_pkg::word_t     rs2_data,
   input  rv_pkg::word_t     data_rdata,
   input  rv_pkg::mem_size_e mem_size,
   input  logic              mem_write,
   output rv_pkg::word_t     wdata,
   output rv_pkg::bytesel_t  bytesel,
   output rv_pkg::word_t     load_data
);

   logic [1:0]    offset;
   logic [7:0]    rd_byte;
   rv_pkg::word_t rd_shift;

   assign offset = alu_res[1:0];

   // ==================================================
   // store side
   // ==================================================
   always_comb begin
      if (mem_size == rv_pkg::SIZE_WORD) begin
         wdata   = rs2_data;
         bytesel = {4{mem_write}};
      end else begin
         wdata   = {24'b0, rs2_data[7:0]} << {offset, 3'b000};
         bytesel = {3'b000, mem_write} << offset;
      end
   end

   // ==================================================
   // load side
   // ==================================================
   assign rd_shift = data_rdata >> {offset, 3'b000};
   assign rd_byte  = rd_shift[7:0];

   always_comb begin
      case (mem_size)
         rv_pkg::SIZE_BYTE:   load_data = {{24{rd_byte[7]}}, rd_byte};
         rv_pkg::SIZE_BYTE_U: load_data = {24'b0, rd_byte};
         default:             load_data = data_rdata;
      endcase
   end

endmodule

// ==== logic/rv_params.svh ====
// ==================================================
// core-wide widths and reset values
// the register count must be a power of two
// code memory starts at RV_RESET_PC, word aligned
// ==================================================
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REG_COUNT 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP_WORD 32'h0000_0013

`endif

// ==== logic/rv_pkg.sv ====
// ==================================================
// types and control encodings shared by the core
// enum values are local to this core, not RISC-V fields
// ==================================================
`include "rv_params.svh"

package rv_pkg;

   typedef logic [`RV_XLEN-1:0] word_t;
   typedef logic [`RV_XLEN-1:0] addr_t;
   typedef logic [31:0] instr_t;
   typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;
   typedef logic [3:0] bytesel_t;

   // ==================================================
   // control encodings
   // ==================================================
   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_PASSB
   } alu_op_e;

   typedef enum logic {OPA_RS1, OPA_PC} opa_sel_e;

   typedef enum logic [1:0] {OPB_RS2, OPB_IMM_I, OPB_IMM_S, OPB_IMM_U} opb_sel_e;

   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

   typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP} pc_sel_e;

   typedef enum logic [1:0] {SIZE_WORD, SIZE_BYTE, SIZE_BYTE_U} mem_size_e;

   // pipeline flow
   typedef enum logic [1:0] {ST_RESET, ST_CONT, ST_BRANCH, ST_WAITLD} flow_state_e;

endpackage

// ==== logic/rv_regfile.sv ====
// ==================================================
// register file, two async reads, one write
// x0 has no storage and reads as zero
// ==================================================
`include "rv_params.svh"

module rv_regfile (
   input  logic             clk,
   input  logic             rst_n,
   input  rv_pkg::reg_idx_t rs1,
   input  rv_pkg::reg_idx_t rs2,
   input  rv_pkg::reg_idx_t rd,
   input  rv_pkg::word_t    rd_data,
   input  logic             write_en,
   output rv_pkg::word_t    rs1_data,
   output rv_pkg::word_t    rs2_data
);

   rv_pkg::word_t regs [1:`RV_REG_COUNT-1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < `RV_REG_COUNT; i++)
            regs[i] <= '0;
      end else if (write_en && (rd != '0)) begin
         regs[rd] <= rd_data;
      end
   end

   assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== sim.f ====
+incdir+logic
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_regfile.sv
logic/rv_lsu.sv
logic/rv_flow.sv
logic/rv_core.sv
bench/core_assertions.sv
bench/tb_core.sv
